// File: Makefile
# Verilator build and run for the debug serial port testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= jsp_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): tb.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src/jsp_apb_mux.sv
//////////////////////////////////////////////////
// APB4 channel decoder
// Channel select from PADDR and response return
//////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_apb_mux import jsp_pkg::*; (
  input  logic                  PSEL,
  input  logic [APB_ADDR_W-1:0] PADDR,
  input  ch_rd_t [NUM_CH-1:0]   ch_rd_i,
  output logic [NUM_CH-1:0]     sel_o,
  output logic [2:0]            reg_o,
  output logic [7:0]            PRDATA,
  output logic                  PREADY,
  output logic                  PSLVERR
);

  // Address fields
  logic [CH_W-1:0] ch;
  ch_rd_t          rsp;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  // Top bits pick the channel
  assign ch    = PADDR[APB_ADDR_W-1 -: CH_W];
  // Low bits go to every channel
  assign reg_o = PADDR[2:0];

  // One select per channel
  always_comb begin
    sel_o = '0;
    for (int i = 0; i < NUM_CH; i++) begin
      if (PSEL && (ch == CH_W'(i))) begin
        sel_o[i] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////

  // Addressed channel answers
  assign rsp     = ch_rd_i[ch];
  assign PRDATA  = rsp.rdata;
  assign PREADY  = rsp.ready;

  // No error responses
  assign PSLVERR = 1'b0;

endmodule

// File: src/jsp_byte_fifo.sv
//////////////////////////////////////////////////
// Byte FIFO
// Circular buffer with occupancy count and clear
//////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_byte_fifo import jsp_pkg::*; (
  input  logic             PCLK,
  input  logic             PRESETn,
  input  logic             clr_i,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic [7:0]       data_i,
  output logic [7:0]       data_o,
  output logic [CNT_W-1:0] count_o,
  output logic             full_o,
  output logic             empty_o
);

  // Storage
  logic [7:0]       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Qualified strobes
  logic             do_push;
  logic             do_pop;

  // Push into full and pop of empty are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Status
  assign full_o  = (count == CNT_W'(FIFO_DEPTH));
  assign empty_o = (count == '0);
  assign count_o = count;

  // Head byte straight from storage
  assign data_o  = mem[rd_ptr];

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clr_i) begin
      // Clear wins over a same-cycle push or pop
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // Data array
  always_ff @(posedge PCLK) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

// File: src/jsp_channel.sv
//////////////////////////////////////////////////
// Serial port channel
// Rx and tx FIFOs behind a 16550-style register
// window, with IIR, interrupt and credit return
//////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_channel import jsp_pkg::*; #(
  parameter logic [CH_W-1:0] CH_IDX = '0
) (
  input  logic             PCLK,
  input  logic             PRESETn,
  input  dbg_byte_t        rx_push_i,
  input  logic             tx_pop_i,
  input  logic             sel_i,
  input  logic             enable_i,
  input  logic             write_i,
  input  logic [2:0]       reg_i,
  input  logic [7:0]       wdata_i,
  output ch_rd_t           rd_o,
  output logic [7:0]       tx_data_o,
  output logic             tx_empty_o,
  output logic [CNT_W-1:0] credit_o,
  output logic             int_o
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // Rx FIFO, host to software
  logic             rx_push;
  logic             rx_pop;
  logic             rx_clr;
  logic [7:0]       rx_data;
  logic [CNT_W-1:0] rx_count;
  logic             rx_empty;

  // Tx FIFO, software to host
  logic             tx_push;
  logic             tx_clr;
  logic [CNT_W-1:0] tx_count;
  logic             tx_full;
  logic             tx_empty;

  // Bus decode
  logic             ready;
  logic             acc_wr;
  logic             acc_rd;
  logic             fcr_wr;
  logic             iir_rd;
  logic             tx_drained;

  // Registers
  logic [1:0]       ier;
  logic [7:0]       lcr;
  logic [7:0]       scr;
  logic             thr_arm;
  logic [CNT_W-1:0] credit_q;
  logic [7:0]       iir;
  logic [7:0]       lsr;

  //////////////////////////////////////////////////
  // Access decode
  //////////////////////////////////////////////////

  // Only a THR write into a full tx FIFO waits
  assign ready   = ~(write_i & (reg_i == REG_DATA) & tx_full);
  assign acc_wr  = sel_i & enable_i & write_i & ready;
  assign acc_rd  = sel_i & enable_i & ~write_i;

  // FIFO strobes, all in the access phase
  assign tx_push = acc_wr & (reg_i == REG_DATA);
  assign rx_pop  = acc_rd & (reg_i == REG_DATA);
  assign fcr_wr  = acc_wr & (reg_i == REG_IIR_FCR);
  assign iir_rd  = acc_rd & (reg_i == REG_IIR_FCR);

  // FCR bit 1 clears rx, bit 2 clears tx
  assign rx_clr  = fcr_wr & wdata_i[1];
  assign tx_clr  = fcr_wr & wdata_i[2];

  // Host byte addressed to this channel
  assign rx_push = rx_push_i.valid & (rx_push_i.ch == CH_IDX);

  //////////////////////////////////////////////////
  // FIFOs
  //////////////////////////////////////////////////

  jsp_byte_fifo i_rx_fifo (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .clr_i   (rx_clr),
    .push_i  (rx_push),
    .pop_i   (rx_pop),
    .data_i  (rx_push_i.data),
    .data_o  (rx_data),
    .count_o (rx_count),
    .full_o  (),
    .empty_o (rx_empty)
  );

  jsp_byte_fifo i_tx_fifo (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .clr_i   (tx_clr),
    .push_i  (tx_push),
    .pop_i   (tx_pop_i),
    .data_i  (wdata_i),
    .data_o  (tx_data_o),
    .count_o (tx_count),
    .full_o  (tx_full),
    .empty_o (tx_empty)
  );

  assign tx_empty_o = tx_empty;

  //////////////////////////////////////////////////
  // Writable registers
  //////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      ier <= '0;
      lcr <= '0;
      scr <= '0;
    end else if (acc_wr) begin
      case (reg_i)
        REG_IER: ier <= wdata_i[1:0];
        // No divisor latch, LCR is plain storage
        REG_LCR: lcr <= wdata_i;
        REG_SCR: scr <= wdata_i;
        default: begin
        end
      endcase
    end
  end

  // Last byte leaving the tx FIFO
  assign tx_drained = tx_pop_i & (tx_count == CNT_W'(1));

  // THR empty arm bit, set wins over the IIR read clear
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      thr_arm <= 1'b0;
    end else if (tx_push || tx_drained) begin
      thr_arm <= 1'b1;
    end else if (iir_rd && rx_empty) begin
      thr_arm <= 1'b0;
    end
  end

  // Credits back to the host, one cycle after the pop or clear
  // A byte pushed during a clear is discarded too
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      credit_q <= '0;
    end else if (rx_clr) begin
      credit_q <= rx_count + CNT_W'(rx_push);
    end else if (rx_pop && !rx_empty) begin
      credit_q <= CNT_W'(1);
    end else begin
      credit_q <= '0;
    end
  end

  assign credit_o = credit_q;

  //////////////////////////////////////////////////
  // Status, interrupt and read data
  //////////////////////////////////////////////////

  // Rx data outranks THR empty
  always_comb begin
    if (!rx_empty) begin
      iir = IIR_RX_DATA;
    end else if (thr_arm && tx_empty) begin
      iir = IIR_THR_EMPTY;
    end else begin
      iir = IIR_NONE;
    end
  end

  // Bit 0 data ready, bits 5 and 6 transmitter empty
  assign lsr   = {1'b0, tx_empty, tx_empty, 4'b0000, ~rx_empty};

  assign int_o = (~rx_empty & ier[0]) | (thr_arm & tx_empty & ier[1]);

  always_comb begin
    rd_o.ready = ready;
    case (reg_i)
      REG_DATA:    rd_o.rdata = rx_data;
      REG_IER:     rd_o.rdata = {6'b0, ier};
      REG_IIR_FCR: rd_o.rdata = iir;
      REG_LCR:     rd_o.rdata = lcr;
      REG_LSR:     rd_o.rdata = lsr;
      REG_SCR:     rd_o.rdata = scr;
      // MCR and MSR not implemented
      default:     rd_o.rdata = 8'h00;
    endcase
  end

endmodule

// File: src/jsp_dbg_port.sv
//////////////////////////////////////////////////
// Debug-side router
// Host bytes out to channels, tx bytes back to
// the host round-robin under host credits
//////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_dbg_port import jsp_pkg::*; (
  input  logic                   PCLK,
  input  logic                   PRESETn,
  input  dbg_byte_t              dbg_tx_i,
  input  logic                   dbg_rx_credit_i,
  input  logic [NUM_CH-1:0][7:0] tx_data_i,
  input  logic [NUM_CH-1:0]      tx_empty_i,
  output dbg_byte_t              rx_push_o,
  output logic [NUM_CH-1:0]      tx_pop_o,
  output dbg_byte_t              dbg_rx_o
);

  // Host side state
  dbg_byte_t        rx_push_q;
  dbg_byte_t        dbg_rx_q;
  logic [CNT_W-1:0] host_cred_q;

  // Arbiter
  logic [CH_W-1:0]  rr_q;
  logic [CH_W-1:0]  cand;
  logic [CH_W-1:0]  pick;
  logic             found;
  logic             issue;

  //////////////////////////////////////////////////
  // Host to channels
  //////////////////////////////////////////////////

  // Every channel sees this, each keeps its own bytes
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      rx_push_q <= '0;
    end else begin
      rx_push_q <= dbg_tx_i;
    end
  end

  assign rx_push_o = rx_push_q;

  //////////////////////////////////////////////////
  // Channels to host
  //////////////////////////////////////////////////

  // First non-empty tx FIFO starting at the pointer
  always_comb begin
    found = 1'b0;
    pick  = rr_q;
    cand  = rr_q;
    for (int i = 0; i < NUM_CH; i++) begin
      cand = CH_W'((int'(rr_q) + i) % NUM_CH);
      if (!found && !tx_empty_i[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  // At most one byte per cycle, only with a host slot free
  assign issue = found & (host_cred_q != '0);

  always_comb begin
    tx_pop_o = '0;
    if (issue) begin
      tx_pop_o[pick] = 1'b1;
    end
  end

  // Credit counter, pointer and output byte
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      host_cred_q <= CNT_W'(HOST_CREDITS);
      rr_q        <= '0;
      dbg_rx_q    <= '0;
    end else begin
      host_cred_q    <= host_cred_q + CNT_W'(dbg_rx_credit_i) - CNT_W'(issue);
      dbg_rx_q.valid <= issue;
      if (issue) begin
        // Next turn goes to the channel after the winner
        rr_q          <= CH_W'((int'(pick) + 1) % NUM_CH);
        dbg_rx_q.ch   <= pick;
        dbg_rx_q.data <= tx_data_i[pick];
      end
    end
  end

  assign dbg_rx_o = dbg_rx_q;

endmodule

// File: src/jsp_pkg.sv
//////////////////////////////////////////////////
// Debug serial port shared definitions
// Sizes, register map and debug-side carriers
//////////////////////////////////////////////////

package jsp_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int NUM_CH       = 2;
  localparam int CH_W         = 1;
  // Bytes per FIFO, also the initial receive credit per channel
  localparam int FIFO_DEPTH   = 8;
  localparam int PTR_W        = 3;
  localparam int CNT_W        = 4;
  // Host buffer slots for transmit bytes after reset
  localparam int HOST_CREDITS = 4;
  // Bit 3 picks the channel, bits 2..0 the register
  localparam int APB_ADDR_W   = 4;

  //////////////////////////////////////////////////
  // 16550-style register offsets
  //////////////////////////////////////////////////

  localparam logic [2:0] REG_DATA    = 3'd0;
  localparam logic [2:0] REG_IER     = 3'd1;
  localparam logic [2:0] REG_IIR_FCR = 3'd2;
  localparam logic [2:0] REG_LCR     = 3'd3;
  localparam logic [2:0] REG_MCR     = 3'd4;
  localparam logic [2:0] REG_LSR     = 3'd5;
  localparam logic [2:0] REG_MSR     = 3'd6;
  localparam logic [2:0] REG_SCR     = 3'd7;

  // Interrupt identification codes
  localparam logic [7:0] IIR_RX_DATA   = 8'h04;
  localparam logic [7:0] IIR_THR_EMPTY = 8'h02;
  localparam logic [7:0] IIR_NONE      = 8'h01;

  //////////////////////////////////////////////////
  // Carriers
  //////////////////////////////////////////////////

  // One byte on the debug side, either direction
  typedef struct packed {
    logic            valid;
    logic [CH_W-1:0] ch;
    logic [7:0]      data;
  } dbg_byte_t;

  // Receive credits handed back to the host, per channel
  typedef struct packed {
    logic [NUM_CH-1:0][CNT_W-1:0] cnt;
  } credit_ret_t;

  // APB response of one channel
  typedef struct packed {
    logic [7:0] rdata;
    logic       ready;
  } ch_rd_t;

endpackage

// File: src/jsp_top.sv
//////////////////////////////////////////////////
// Two-channel debug serial port
// Debug port, channels and APB decoder
//////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_top import jsp_pkg::*; (
  input  logic                  PCLK,
  input  logic                  PRESETn,
  // APB4 slave
  input  logic                  PSEL,
  input  logic                  PENABLE,
  input  logic                  PWRITE,
  input  logic [APB_ADDR_W-1:0] PADDR,
  input  logic [7:0]            PWDATA,
  output logic [7:0]            PRDATA,
  output logic                  PREADY,
  output logic                  PSLVERR,
  // Debug host
  input  dbg_byte_t             dbg_tx_i,
  input  logic                  dbg_rx_credit_i,
  output dbg_byte_t             dbg_rx_o,
  output credit_ret_t           credit_o,
  output logic                  int_o
);

  // Debug port to channels
  dbg_byte_t                    rx_push;
  logic [NUM_CH-1:0]            tx_pop;
  logic [NUM_CH-1:0][7:0]       tx_data;
  logic [NUM_CH-1:0]            tx_empty;

  // APB decoder to channels
  logic [NUM_CH-1:0]            sel;
  logic [2:0]                   reg_sel;
  ch_rd_t [NUM_CH-1:0]          ch_rd;

  // Per-channel outputs
  logic [NUM_CH-1:0][CNT_W-1:0] ch_credit;
  logic [NUM_CH-1:0]            ch_int;

  jsp_dbg_port i_dbg_port (
    .PCLK            (PCLK),
    .PRESETn         (PRESETn),
    .dbg_tx_i        (dbg_tx_i),
    .dbg_rx_credit_i (dbg_rx_credit_i),
    .tx_data_i       (tx_data),
    .tx_empty_i      (tx_empty),
    .rx_push_o       (rx_push),
    .tx_pop_o        (tx_pop),
    .dbg_rx_o        (dbg_rx_o)
  );

  // Identical channels
  for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
    jsp_channel #(
      .CH_IDX (CH_W'(g))
    ) i_channel (
      .PCLK       (PCLK),
      .PRESETn    (PRESETn),
      .rx_push_i  (rx_push),
      .tx_pop_i   (tx_pop[g]),
      .sel_i      (sel[g]),
      .enable_i   (PENABLE),
      .write_i    (PWRITE),
      .reg_i      (reg_sel),
      .wdata_i    (PWDATA),
      .rd_o       (ch_rd[g]),
      .tx_data_o  (tx_data[g]),
      .tx_empty_o (tx_empty[g]),
      .credit_o   (ch_credit[g]),
      .int_o      (ch_int[g])
    );
  end

  jsp_apb_mux i_apb_mux (
    .PSEL    (PSEL),
    .PADDR   (PADDR),
    .ch_rd_i (ch_rd),
    .sel_o   (sel),
    .reg_o   (reg_sel),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR)
  );

  // Combined interrupt and credit bundle
  assign int_o        = |ch_int;
  assign credit_o.cnt = ch_credit;

endmodule

// File: tb.f
src/jsp_pkg.sv
src/jsp_byte_fifo.sv
src/jsp_channel.sv
src/jsp_dbg_port.sv
src/jsp_apb_mux.sv
src/jsp_top.sv
test/jsp_asserts.sv
test/jsp_tb.sv

// File: test/jsp_asserts.sv
//////////////////////////////////////////////////
// Debug-side protocol assertions
// Credit bookkeeping in both directions
//////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_asserts import jsp_pkg::*; (
  input logic        PCLK,
  input logic        PRESETn,
  input dbg_byte_t   dbg_tx_i,
  input logic        dbg_rx_credit_i,
  input dbg_byte_t   dbg_rx_o,
  input credit_ret_t credit_o
);

  // Receive credits the host holds, per channel
  int rx_cred [NUM_CH];
  // Host buffer slots still open for the port
  int tx_cred;

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      for (int c = 0; c < NUM_CH; c++) begin
        rx_cred[c] <= FIFO_DEPTH;
      end
      tx_cred <= HOST_CREDITS;
    end else begin
      for (int c = 0; c < NUM_CH; c++) begin
        rx_cred[c] <= rx_cred[c] + int'(credit_o.cnt[c])
                      - int'(dbg_tx_i.valid && (int'(dbg_tx_i.ch) == c));
      end
      tx_cred <= tx_cred + int'(dbg_rx_credit_i) - int'(dbg_rx_o.valid);
    end
  end

  for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
    // Returned credits fit in the rx FIFO
    a_cred_ret: assert property (@(posedge PCLK) disable iff (!PRESETn)
      rx_cred[g] + int'(credit_o.cnt[g]) <= FIFO_DEPTH)
      else $error("Channel %0d credit return above FIFO depth", g);

    // Host byte only with a credit in hand
    a_host_tx: assert property (@(posedge PCLK) disable iff (!PRESETn)
      (dbg_tx_i.valid && int'(dbg_tx_i.ch) == g) |-> rx_cred[g] > 0)
      else $error("Channel %0d host byte without a credit", g);
  end

  // Port byte needs an open host slot
  a_port_tx: assert property (@(posedge PCLK) disable iff (!PRESETn)
    dbg_rx_o.valid |-> tx_cred > 0)
    else $error("Port byte sent without a host slot");

endmodule

bind jsp_top jsp_asserts i_jsp_asserts (
  .PCLK            (PCLK),
  .PRESETn         (PRESETn),
  .dbg_tx_i        (dbg_tx_i),
  .dbg_rx_credit_i (dbg_rx_credit_i),
  .dbg_rx_o        (dbg_rx_o),
  .credit_o        (credit_o)
);

// File: test/jsp_tb.sv
//////////////////////////////////////////////////
// Debug serial port testbench
// APB and debug-host drivers, reference queues,
// checking assertions and a watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_tb import jsp_pkg::*; ();

  localparam int CLK_PERIOD  = 4;
  // Rough cycle count of all tests together
  localparam int TEST_CYCLES = 450;

  logic                  PCLK;
  logic                  PRESETn;
  logic                  PSEL;
  logic                  PENABLE;
  logic                  PWRITE;
  logic [APB_ADDR_W-1:0] PADDR;
  logic [7:0]            PWDATA;
  logic [7:0]            PRDATA;
  logic                  PREADY;
  logic                  PSLVERR;
  dbg_byte_t             dbg_tx;
  logic                  dbg_rx_credit;
  dbg_byte_t             dbg_rx;
  credit_ret_t           credit;
  logic                  irq;

  // Reference model, bytes in flight per channel and direction
  logic [7:0] rx_exp [NUM_CH][$];
  logic [7:0] tx_exp [NUM_CH][$];
  // Receive credits the host holds
  int         host_rx_cred [NUM_CH];
  // Credits expected on credit_o in the current cycle
  int         cred_due [NUM_CH];
  // Transmit side, slots granted and bytes seen
  int         granted;
  int         delivered;

  initial PCLK = 1'b0;
  always #(CLK_PERIOD / 2) PCLK = ~PCLK;

  jsp_top i_jsp_top (
    .PCLK            (PCLK),
    .PRESETn         (PRESETn),
    .PSEL            (PSEL),
    .PENABLE         (PENABLE),
    .PWRITE          (PWRITE),
    .PADDR           (PADDR),
    .PWDATA          (PWDATA),
    .PRDATA          (PRDATA),
    .PREADY          (PREADY),
    .PSLVERR         (PSLVERR),
    .dbg_tx_i        (dbg_tx),
    .dbg_rx_credit_i (dbg_rx_credit),
    .dbg_rx_o        (dbg_rx),
    .credit_o        (credit),
    .int_o           (irq)
  );

  //////////////////////////////////////////////////
  // Error reporting and checks
  //////////////////////////////////////////////////

  task automatic report_value(input string name, input int got, input int exp);
    $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    $display("Finished with errors");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_problem(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Finished with errors");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp) else report_value(name, got, exp);
  endtask

  // Tx FIFOs idle, bit 0 tracks pending rx bytes
  function automatic logic [7:0] expected_lsr(input int ch);
    return {7'h30, rx_exp[ch].size() != 0};
  endfunction

  // Bus never flags an error
  assert property (@(posedge PCLK) disable iff (!PRESETn) !PSLVERR)
    else report_value("PSLVERR", PSLVERR, 0);

  // Only a THR write may stretch the access phase
  assert property (@(posedge PCLK) disable iff (!PRESETn)
    (PSEL && PENABLE && !PREADY) |-> (PWRITE && PADDR[2:0] == REG_DATA))
    else report_problem("PREADY held low outside a THR write");

  // Debug-side monitor, sampled mid-cycle where outputs are stable
  always @(negedge PCLK) begin
    if (PRESETn) begin
      for (int c = 0; c < NUM_CH; c++) begin
        check_value($sformatf("credit_o.cnt[%0d]", c), credit.cnt[c], cred_due[c]);
        host_rx_cred[c] += credit.cnt[c];
        cred_due[c] = 0;
      end
      if (dbg_rx.valid) begin
        delivered++;
        assert (delivered <= HOST_CREDITS + granted)
          else report_problem("dbg_rx_o sent a byte without a host credit");
        assert (tx_exp[dbg_rx.ch].size() != 0)
          else report_problem("dbg_rx_o sent a byte nobody wrote");
        check_value("dbg_rx_o.data", dbg_rx.data, tx_exp[dbg_rx.ch].pop_front());
      end
      // Granted slot is usable from the next cycle on
      if (dbg_rx_credit) begin
        granted++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  // Setup phase, access phase, wait for PREADY
  task automatic apb_access(input logic wr, input int ch, input logic [2:0] reg_off,
                            input logic [7:0] wdata, output logic [7:0] rdata);
    @(posedge PCLK);
    #1;
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = wr;
    PADDR   = {ch[CH_W-1:0], reg_off};
    PWDATA  = wdata;
    @(posedge PCLK);
    #1;
    PENABLE = 1'b1;
    // Response is stable by the falling edge
    @(negedge PCLK);
    while (!PREADY) begin
      @(negedge PCLK);
    end
    rdata = PRDATA;
    @(posedge PCLK);
    #1;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic reg_write(input int ch, input logic [2:0] reg_off, input logic [7:0] data);
    logic [7:0] dummy;
    apb_access(1'b1, ch, reg_off, data, dummy);
  endtask

  task automatic reg_check(input int ch, input logic [2:0] reg_off,
                           input logic [7:0] exp, input string name);
    logic [7:0] got;
    apb_access(1'b0, ch, reg_off, 8'h00, got);
    check_value($sformatf("ch%0d %s", ch, name), got, exp);
  endtask

  // Data read pops one byte and owes one credit
  task automatic read_rx(input int ch);
    logic [7:0] got;
    logic [7:0] exp;
    exp = rx_exp[ch].pop_front();
    apb_access(1'b0, ch, REG_DATA, 8'h00, got);
    cred_due[ch] = 1;
    check_value($sformatf("ch%0d DATA", ch), got, exp);
  endtask

  task automatic host_send(input int ch, input logic [7:0] data);
    assert (host_rx_cred[ch] > 0) else report_problem("host sent without a credit");
    @(posedge PCLK);
    #1;
    dbg_tx.valid = 1'b1;
    dbg_tx.ch    = ch[CH_W-1:0];
    dbg_tx.data  = data;
    host_rx_cred[ch]--;
    rx_exp[ch].push_back(data);
    @(posedge PCLK);
    #1;
    dbg_tx.valid = 1'b0;
  endtask

  // Byte lands in the rx FIFO two edges after it is sampled
  task automatic settle_rx();
    repeat (2) @(posedge PCLK);
    #1;
  endtask

  // One-cycle credit pulses with random gaps
  task automatic grant_credits(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge PCLK);
      #1;
      dbg_rx_credit = 1'b1;
      @(posedge PCLK);
      #1;
      dbg_rx_credit = 1'b0;
      repeat ($urandom_range(2)) @(posedge PCLK);
    end
  endtask

  task automatic wait_tx_drained();
    while (tx_exp[0].size() != 0 || tx_exp[1].size() != 0) begin
      @(posedge PCLK);
    end
    #1;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    int unsigned seed;
    int          ch;
    int          n;
    logic [7:0]  data;
    seed = 32'h3050_ac20;
    void'($urandom(seed));
    PRESETn       = 1'b0;
    PSEL          = 1'b0;
    PENABLE       = 1'b0;
    PWRITE        = 1'b0;
    PADDR         = '0;
    PWDATA        = '0;
    dbg_tx        = '0;
    dbg_rx_credit = 1'b0;
    granted       = 0;
    delivered     = 0;
    for (int c = 0; c < NUM_CH; c++) begin
      host_rx_cred[c] = FIFO_DEPTH;
      cred_due[c]     = 0;
    end
    repeat (2) @(posedge PCLK);
    #1;
    PRESETn = 1'b1;

    // Reset values
    check_value("int_o", irq, 0);
    check_value("dbg_rx_o.valid", dbg_rx.valid, 0);
    check_value("credit_o", credit, 0);
    for (int c = 0; c < NUM_CH; c++) begin
      reg_check(c, REG_LSR, 8'h60, "LSR");
      reg_check(c, REG_IIR_FCR, IIR_NONE, "IIR");
      reg_check(c, REG_IER, 8'h00, "IER");
      reg_check(c, REG_LCR, 8'h00, "LCR");
      reg_check(c, REG_SCR, 8'h00, "SCR");
    end

    // Host to software on both channels
    for (int i = 0; i < 12; i++) begin
      ch = $urandom_range(NUM_CH - 1);
      if (host_rx_cred[ch] == 0) begin
        ch = (ch + 1) % NUM_CH;
      end
      host_send(ch, 8'($urandom));
    end
    settle_rx();
    for (int c = 0; c < NUM_CH; c++) begin
      reg_check(c, REG_LSR, expected_lsr(c), "LSR");
    end
    while (rx_exp[0].size() + rx_exp[1].size() != 0) begin
      ch = $urandom_range(NUM_CH - 1);
      if (rx_exp[ch].size() == 0) begin
        ch = (ch + 1) % NUM_CH;
      end
      read_rx(ch);
      reg_check(ch, REG_LSR, expected_lsr(ch), "LSR");
    end

    // Software to host, initial slots then trickled grants
    for (int i = 0; i < 10; i++) begin
      ch   = $urandom_range(NUM_CH - 1);
      data = 8'($urandom);
      reg_write(ch, REG_DATA, data);
      tx_exp[ch].push_back(data);
    end
    grant_credits(10);
    wait_tx_drained();

    // Back-pressure, host slots used up then tx FIFO full
    for (int i = 0; i < HOST_CREDITS + FIFO_DEPTH; i++) begin
      data = 8'($urandom);
      reg_write(0, REG_DATA, data);
      tx_exp[0].push_back(data);
    end
    data = 8'($urandom);
    fork
      begin
        reg_write(0, REG_DATA, data);
        tx_exp[0].push_back(data);
      end
      begin
        repeat (6) begin
          @(negedge PCLK);
          if (PSEL && PENABLE) begin
            check_value("PREADY", PREADY, 0);
          end
        end
        grant_credits(1);
      end
    join
    grant_credits(FIFO_DEPTH);
    wait_tx_drained();

    // Scratch and line control storage
    for (int c = 0; c < NUM_CH; c++) begin
      data = 8'($urandom);
      reg_write(c, REG_SCR, data);
      reg_check(c, REG_SCR, data, "SCR");
      data = 8'($urandom);
      reg_write(c, REG_LCR, data);
      reg_check(c, REG_LCR, data, "LCR");
    end

    // Rx data interrupt on channel 0
    reg_write(0, REG_IER, 8'h01);
    check_value("int_o", irq, 0);
    host_send(0, 8'($urandom));
    settle_rx();
    check_value("int_o", irq, 1);
    reg_check(0, REG_IIR_FCR, IIR_RX_DATA, "IIR");
    read_rx(0);
    check_value("int_o", irq, 0);
    reg_write(0, REG_IER, 8'h00);

    // THR empty interrupt on channel 1
    reg_write(1, REG_IER, 8'h02);
    data = 8'($urandom);
    reg_write(1, REG_DATA, data);
    tx_exp[1].push_back(data);
    check_value("int_o", irq, 0);
    grant_credits(1);
    wait_tx_drained();
    check_value("int_o", irq, 1);
    reg_check(1, REG_IIR_FCR, IIR_THR_EMPTY, "IIR");
    check_value("int_o", irq, 0);
    reg_check(1, REG_IIR_FCR, IIR_NONE, "IIR");
    reg_write(1, REG_IER, 8'h00);

    // FCR rx clear on channel 0, channel 1 keeps its bytes
    n = $urandom_range(5, 2);
    for (int i = 0; i < n; i++) begin
      host_send(0, 8'($urandom));
    end
    host_send(1, 8'($urandom));
    host_send(1, 8'($urandom));
    settle_rx();
    reg_write(0, REG_IIR_FCR, 8'h02);
    cred_due[0] = n;
    rx_exp[0].delete();
    reg_check(0, REG_LSR, expected_lsr(0), "LSR");
    reg_check(1, REG_LSR, expected_lsr(1), "LSR");
    while (rx_exp[1].size() != 0) begin
      read_rx(1);
    end

    // Every receive credit is back with the host
    @(posedge PCLK);
    #1;
    for (int c = 0; c < NUM_CH; c++) begin
      check_value($sformatf("host credits ch%0d", c), host_rx_cred[c], FIFO_DEPTH);
    end

    $display("Finished with no errors");
    $finish;
  end

  // Watchdog
  initial begin
    #(TEST_CYCLES * 4 * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d cycles", TEST_CYCLES * 4);
    $display("Finished with errors");
    $fatal(1, "Watchdog expired");
  end

endmodule
